/* Bender.yml */
package:
  name: ras_predictor

sources:
  - rtl/ras_pkg.sv
  - rtl/link_decode.sv
  - rtl/return_stack.sv
  - rtl/next_pc_select.sv
  - rtl/ras_predictor_top.sv
  - target: test
    files:
      - testbench/ras_predictor_assertions.sv
      - testbench/ras_predictor_tb.sv

/* filelist.f */
rtl/ras_pkg.sv
rtl/link_decode.sv
rtl/return_stack.sv
rtl/next_pc_select.sv
rtl/ras_predictor_top.sv
testbench/ras_predictor_assertions.sv
testbench/ras_predictor_tb.sv

/* rtl/link_decode.sv */
`timescale 1ns/1ps

module link_decode
(
    input  logic                         new_inst,
    input  ras_pkg::rv32i_word           pc,
    input  ras_pkg::rv32i_word           inst,
    input  ras_pkg::thread_id_t          thread_id,
    output ras_pkg::ras_req_t            req,
    output logic [ras_pkg::N_THREADS-1:0] req_valid,
    output ras_pkg::rv32i_word           fall_through
);

    import ras_pkg::*;

    rv32i_opcode opcode;
    rv32i_reg    rd;
    rv32i_reg    rs1;
    logic        link_rd;
    logic        link_rs1;
    logic        push;
    logic        pop;
    rv32i_word   seq_pc;

    assign opcode = rv32i_opcode'(inst[6:0]);
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];

    assign link_rd  = (rd == LINK_X1) || (rd == LINK_X5);
    assign link_rs1 = (rs1 == LINK_X1) || (rs1 == LINK_X5);

    always_comb
    begin
        push = 1'b0;
        pop  = 1'b0;
        if ((opcode == op_jal) && link_rd)
        begin
            push = 1'b1;                // Call
        end
        else if (opcode == op_jalr)
        begin
            if (link_rs1 && !link_rd)
            begin
                pop = 1'b1;             // Return
            end
            else if (link_rd && !link_rs1)
            begin
                push = 1'b1;            // Indirect call
            end
            else if (link_rd && link_rs1)
            begin
                push = 1'b1;
                pop  = (rd != rs1);     // Coroutine swap when the registers differ
            end
        end
    end

    // One adder serves both the return address and the fallback
    assign seq_pc       = pc + rv32i_word'(INST_BYTES);
    assign fall_through = seq_pc;

    assign req.push     = push;
    assign req.pop      = pop;
    assign req.ret_addr = seq_pc;

    always_comb
    begin
        req_valid = '0;
        if (new_inst)
        begin
            req_valid[thread_id] = 1'b1;   // Steer to the fetching thread only
        end
    end

endmodule

/* rtl/next_pc_select.sv */
`timescale 1ns/1ps

module next_pc_select
(
    input  ras_pkg::thread_id_t thread_id,
    input  ras_pkg::ras_resp_t  resp [ras_pkg::N_THREADS],
    input  ras_pkg::rv32i_word  fall_through,
    output ras_pkg::rv32i_word  pc_next
);

    import ras_pkg::*;

    ras_resp_t sel;

    // Only the fetching thread's stack can predict this cycle
    assign sel = resp[thread_id];

    always_comb
    begin
        if (sel.hit)
        begin
            pc_next = sel.target;       // Predicted return target
        end
        else
        begin
            pc_next = fall_through;
        end
    end

endmodule

/* rtl/ras_pkg.sv */
package ras_pkg;

    // Base RV32I words and register indices
    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // Major opcodes of the base integer ISA
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_fence = 7'b0001111,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    // Link registers named by the calling convention hints
    localparam rv32i_reg LINK_X1 = 5'd1;
    localparam rv32i_reg LINK_X5 = 5'd5;

    // Byte size of one uncompressed instruction
    localparam int unsigned INST_BYTES = 4;

    // Each hardware thread of the barrel core has its own return stack
    localparam int unsigned N_THREADS = 4;

    typedef logic [$clog2(N_THREADS)-1:0] thread_id_t;

    // Entries per return stack
    localparam int unsigned STACK_DEPTH = 15;

    // Holds 0 when empty up to STACK_DEPTH when full
    typedef logic [$clog2(STACK_DEPTH+1)-1:0] stack_ptr_t;

    // Request from the link decoder to one stack
    typedef struct packed {
        logic      push;
        logic      pop;
        rv32i_word ret_addr;
    } ras_req_t;

    // Prediction returned by a stack
    typedef struct packed {
        logic      hit;
        rv32i_word target;
    } ras_resp_t;

endpackage

/* rtl/ras_predictor_top.sv */
`timescale 1ns/1ps

module ras_predictor_top
(
    input  logic                clk,
    input  logic                rst,
    input  logic                new_inst,
    input  ras_pkg::rv32i_word  pc,
    input  ras_pkg::rv32i_word  inst,
    input  ras_pkg::thread_id_t thread_id,
    output ras_pkg::rv32i_word  pc_next
);

    import ras_pkg::*;

    ras_req_t               req;
    logic [N_THREADS-1:0]   req_valid;
    rv32i_word              fall_through;
    ras_resp_t              resp [N_THREADS];

    link_decode u_decode
    (
        .new_inst     (new_inst),
        .pc           (pc),
        .inst         (inst),
        .thread_id    (thread_id),
        .req          (req),
        .req_valid    (req_valid),
        .fall_through (fall_through)
    );

    // One stack per hardware thread and all of them see the same request
    for (genvar i = 0; i < N_THREADS; i++)
    begin : g_stack
        return_stack u_stack
        (
            .clk       (clk),
            .rst       (rst),
            .req_valid (req_valid[i]),
            .req       (req),
            .resp      (resp[i])
        );
    end

    next_pc_select u_select
    (
        .thread_id    (thread_id),
        .resp         (resp),
        .fall_through (fall_through),
        .pc_next      (pc_next)
    );

endmodule

/* rtl/return_stack.sv */
`timescale 1ns/1ps

module return_stack
(
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  ras_pkg::ras_req_t req,
    output ras_pkg::ras_resp_t resp
);

    import ras_pkg::*;

    rv32i_word  entries [STACK_DEPTH];
    stack_ptr_t ptr;                // First free slot
    stack_ptr_t ptr_nxt;
    stack_ptr_t top_idx;
    stack_ptr_t wr_idx;
    logic       wr_en;
    logic       empty;
    logic       full;

    assign empty = (ptr == '0);
    assign full  = (ptr == stack_ptr_t'(STACK_DEPTH));

    // Slot below the pointer that is pinned to slot 0 while empty
    assign top_idx = empty ? '0 : ptr - stack_ptr_t'(1);

    always_comb
    begin
        ptr_nxt = ptr;
        wr_en   = 1'b0;
        wr_idx  = ptr;
        if (req_valid)
        begin
            if (req.push && req.pop)
            begin
                if (!empty)
                begin
                    wr_en  = 1'b1;      // Replace the top entry in place
                    wr_idx = top_idx;
                end
                else
                begin
                    wr_en   = 1'b1;     // Nothing to pop so this is a plain push
                    wr_idx  = ptr;
                    ptr_nxt = ptr + stack_ptr_t'(1);
                end
            end
            else if (req.push)
            begin
                if (!full)
                begin
                    wr_en   = 1'b1;
                    wr_idx  = ptr;
                    ptr_nxt = ptr + stack_ptr_t'(1);
                end
                // A push onto a full stack is dropped
            end
            else if (req.pop)
            begin
                if (!empty)
                begin
                    ptr_nxt = ptr - stack_ptr_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ptr <= '0;
        end
        else
        begin
            ptr <= ptr_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < STACK_DEPTH; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            entries[wr_idx] <= req.ret_addr;
        end
    end

    assign resp.hit    = req_valid && req.pop && !empty;
    assign resp.target = entries[top_idx];

endmodule

/* testbench/ras_predictor_assertions.sv */
`timescale 1ns/1ps

module ras_predictor_assertions
(
    input logic                clk,
    input logic                rst,
    input logic                req_valid,
    input ras_pkg::ras_req_t   req,
    input ras_pkg::stack_ptr_t ptr,
    input ras_pkg::ras_resp_t  resp
);

    import ras_pkg::*;

    int unsigned error_count = 0;

    // A full stack only holds or pops so the pointer never wraps past the depth
    ptr_in_range: assert property (@(posedge clk) disable iff (rst)
        (ptr == STACK_DEPTH) |=> (ptr >= STACK_DEPTH - 1))
    else
    begin
        $error("stack pointer ran past the stack depth");
        error_count++;
    end

    // A pop that hits must leave a nonzero pointer one lower
    hit_pops_top: assert property (@(posedge clk) disable iff (rst)
        (resp.hit && !req.push) |=> (ptr == $past(ptr) - 1))
    else
    begin
        $error("hit reported without the stack pointer dropping by one");
        error_count++;
    end

    // Only a request to this thread may move its pointer
    ptr_idle_stable: assert property (@(posedge clk) disable iff (rst)
        !req_valid |=> $stable(ptr))
    else
    begin
        $error("stack pointer changed without a request");
        error_count++;
    end

endmodule

bind return_stack ras_predictor_assertions u_assert
(
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .ptr       (ptr),
    .resp      (resp)
);

/* testbench/ras_predictor_tb.sv */
`timescale 1ns/1ps

module ras_predictor_tb;

    import ras_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_RANDOM   = 8;

    typedef struct packed {
        logic       new_inst;
        thread_id_t thread_id;
        rv32i_word  pc;
        rv32i_word  inst;
        rv32i_word  exp_next;
    } vec_t;

    logic       clk;
    logic       rst;
    logic       new_inst;
    rv32i_word  pc;
    rv32i_word  inst;
    thread_id_t thread_id;
    rv32i_word  pc_next;

    vec_t   table_q [$];
    string  names_q [$];
    int     pass_count = 0;
    int     fail_count = 0;
    integer seed       = 32'h9131;

    ras_predictor_top dut0
    (
        .clk       (clk),
        .rst       (rst),
        .new_inst  (new_inst),
        .pc        (pc),
        .inst      (inst),
        .thread_id (thread_id),
        .pc_next   (pc_next)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic rv32i_word enc_jal(input rv32i_reg rd);
        return {20'h0, rd, op_jal};     // Zero offset since only the link hints matter
    endfunction

    function automatic rv32i_word enc_jalr(input rv32i_reg rd, input rv32i_reg rs1);
        return {12'h0, rs1, 3'b000, rd, op_jalr};
    endfunction

    function automatic int assert_error_count();
        return dut0.g_stack[0].u_stack.u_assert.error_count
             + dut0.g_stack[1].u_stack.u_assert.error_count
             + dut0.g_stack[2].u_stack.u_assert.error_count
             + dut0.g_stack[3].u_stack.u_assert.error_count;
    endfunction

    task automatic add_vec(input logic ni, input thread_id_t tid, input rv32i_word p,
                           input rv32i_word ins, input rv32i_word exp, input string name);
        vec_t v;
        v.new_inst  = ni;
        v.thread_id = tid;
        v.pc        = p;
        v.inst      = ins;
        v.exp_next  = exp;
        table_q.push_back(v);
        names_q.push_back(name);
    endtask

    task automatic build_table();
        // Strobe low or no jump gives pc + 4
        add_vec(1'b0, 0, 32'h100, enc_jal(LINK_X1), 32'h104, "idle_jal");
        add_vec(1'b0, 0, 32'h200, enc_jalr(0, LINK_X1), 32'h204, "idle_ret");
        add_vec(1'b1, 0, 32'h300, 32'h00500093, 32'h304, "addi_x1");
        add_vec(1'b1, 0, 32'h310, enc_jalr(0, LINK_X1), 32'h314, "ret_empty");
        // Nested calls on thread 0
        add_vec(1'b1, 0, 32'h1000, enc_jal(LINK_X1), 32'h1004, "call_a");
        add_vec(1'b1, 0, 32'h2000, enc_jal(LINK_X1), 32'h2004, "call_b");
        add_vec(1'b1, 0, 32'h3000, enc_jal(LINK_X5), 32'h3004, "call_c_x5");
        add_vec(1'b1, 0, 32'h3100, enc_jalr(0, LINK_X5), 32'h3004, "ret_c");
        add_vec(1'b1, 0, 32'h2100, enc_jalr(0, LINK_X1), 32'h2004, "ret_b");
        add_vec(1'b1, 0, 32'h1100, enc_jalr(0, LINK_X1), 32'h1004, "ret_a");
        // Coroutine swap and indirect calls on thread 1
        add_vec(1'b1, 1, 32'h4000, enc_jal(LINK_X1), 32'h4004, "call_co");
        add_vec(1'b1, 1, 32'h5000, enc_jalr(LINK_X5, LINK_X1), 32'h4004, "swap_x5_x1");
        add_vec(1'b1, 1, 32'h5100, enc_jalr(0, LINK_X5), 32'h5004, "ret_after_swap");
        add_vec(1'b1, 1, 32'h6000, enc_jalr(LINK_X1, LINK_X1), 32'h6004, "jalr_x1_x1");
        add_vec(1'b1, 1, 32'h6100, enc_jalr(0, LINK_X1), 32'h6004, "ret_jalr_x1");
        add_vec(1'b1, 1, 32'h6200, enc_jalr(LINK_X1, LINK_X5), 32'h6204, "swap_empty");
        add_vec(1'b1, 1, 32'h6300, enc_jalr(0, LINK_X1), 32'h6204, "ret_swap_empty");
        // Overfill thread 2 so the sixteenth push is dropped
        for (int k = 0; k < 16; k++)
        begin
            add_vec(1'b1, 2, 32'h8000 + k * 32'h100, enc_jal(LINK_X1),
                    32'h8004 + k * 32'h100, $sformatf("fill_call_%0d", k));
        end
        for (int k = 0; k < 15; k++)
        begin
            add_vec(1'b1, 2, 32'h9000 + k * 32'h10, enc_jalr(0, LINK_X1),
                    32'h8004 + (14 - k) * 32'h100, $sformatf("drain_ret_%0d", k));
        end
        add_vec(1'b1, 2, 32'h90f0, enc_jalr(0, LINK_X1), 32'h90f4, "drain_ret_empty");
        // Threads interleaved
        add_vec(1'b1, 0, 32'hA000, enc_jal(LINK_X1), 32'hA004, "t0_call");
        add_vec(1'b1, 1, 32'hB000, enc_jal(LINK_X1), 32'hB004, "t1_call");
        add_vec(1'b1, 2, 32'hC000, enc_jal(LINK_X5), 32'hC004, "t2_call");
        add_vec(1'b1, 3, 32'hD000, enc_jal(LINK_X1), 32'hD004, "t3_call_outer");
        add_vec(1'b1, 3, 32'hD100, enc_jal(LINK_X1), 32'hD104, "t3_call_inner");
        add_vec(1'b1, 0, 32'hA100, enc_jalr(0, LINK_X1), 32'hA004, "t0_ret");
        add_vec(1'b1, 2, 32'hC100, enc_jalr(0, LINK_X5), 32'hC004, "t2_ret");
        add_vec(1'b1, 3, 32'hD200, enc_jalr(0, LINK_X1), 32'hD104, "t3_ret_inner");
        add_vec(1'b1, 1, 32'hB100, enc_jalr(0, LINK_X1), 32'hB004, "t1_ret");
        add_vec(1'b1, 0, 32'hA200, enc_jalr(0, LINK_X1), 32'hA204, "t0_ret_empty");
        add_vec(1'b1, 3, 32'hD300, enc_jalr(0, LINK_X1), 32'hD004, "t3_ret_outer");
        add_vec(1'b1, 2, 32'hC200, enc_jalr(0, LINK_X1), 32'hC204, "t2_ret_empty");
    endtask

    task automatic apply_vec(input vec_t v, input string name);
        @(posedge clk);
        #5;
        new_inst  = v.new_inst;
        thread_id = v.thread_id;
        pc        = v.pc;
        inst      = v.inst;
        #(CLK_PERIOD - 15);            // Sample just before the next edge
        if (pc_next !== v.exp_next)
        begin
            $display("MISMATCH at %0t: %s pc_next expected %h, got %h",
                     $time, name, v.exp_next, pc_next);
            fail_count++;
            $display("%-20s FAIL", name);
        end
        else
        begin
            pass_count++;
            $display("%-20s ok", name);
        end
    endtask

    initial
    begin
        vec_t      v;
        rv32i_word r;
        rv32i_word p;
        build_table();
        rst       = 1'b1;
        new_inst  = 1'b0;
        thread_id = '0;
        pc        = '0;
        inst      = '0;
        repeat (10) @(posedge clk);
        #5 rst = 1'b0;
        for (int i = 0; i < table_q.size(); i++)
        begin
            apply_vec(table_q[i], names_q[i]);
        end
        for (int k = 0; k < N_RANDOM; k++)
        begin
            r           = $random(seed);
            p           = $random(seed);
            v.new_inst  = 1'b1;
            v.thread_id = r[6:5];
            v.pc        = {p[31:2], 2'b00};
            v.inst      = {r[31:7], (r[0] ? op_imm : op_reg)};   // Never a jump
            v.exp_next  = v.pc + 32'd4;
            apply_vec(v, $sformatf("random_alu_%0d", k));
        end
        $display("%0d checks passed, %0d checks failed, %0d assertion errors",
                 pass_count, fail_count, assert_error_count());
        if ((fail_count == 0) && (assert_error_count() == 0))
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

    initial
    begin
        #1;
        #((table_q.size() + N_RANDOM + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the expected number of cycles");
        $display("test failed");
        $finish;
    end

endmodule
